// File: all.f
+incdir+tests
verilog/isaPkg.sv
verilog/decodePkg.sv
verilog/scalarRegFile.sv
verilog/vecWriteRouter.sv
verilog/vectorLane.sv
verilog/vecOperandGather.sv
verilog/scoreboard.sv
verilog/instDecoder.sv
verilog/decodeStage.sv
tests/decodeTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds and runs the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module decodeTb -f all.f -o decodeSim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Build failed, see build.log"
  exit 1
fi

./obj_dir/decodeSim > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "TB FAILED" sim.log; then
  echo "Simulation reported failure, see sim.log"
  exit 1
fi

echo "Simulation finished without failure"
exit 0

// File: tests/tbTasks.svh
//////////////////////////////
// Instruction encoding
//////////////////////////////
function automatic logic [31:0] encAlu(opcodeT op, regIdxT d, regIdxT s1, regIdxT s2);
  return {op, d, s1, 4'h0, s2, 8'h00}; // Rs2 sits inside the imm field
endfunction

function automatic logic [31:0] encImm(opcodeT op, regIdxT d, regIdxT s1, logic [15:0] i);
  return {op, d, s1, i};
endfunction

function automatic logic [31:0] encVec(opcodeT op, compIdxT c, regIdxT vd, regIdxT vs1,
                                       regIdxT vs2);
  return {op, c, 2'b00, vd, 4'h0, vs1, 4'h0, vs2};
endfunction

function automatic logic [31:0] encBr(opcodeT op, logic [2:0] mask);
  return {op, mask, 21'h0}; // n/z/p in bits 23..21
endfunction

//////////////////////////////
// Writeback drivers
//////////////////////////////
// Each one holds its enable for exactly one edge
task automatic scalarWb(regIdxT idx, logic [15:0] d);
  @(posedge I_CLOCK);
  wbEn <= 1'b1;
  wbIdx <= idx;
  wbData <= d;
  @(posedge I_CLOCK);
  wbEn <= 1'b0;
endtask

task automatic vecFullWb(regIdxT idx, logic [63:0] d);
  @(posedge I_CLOCK);
  vecWbEn <= 1'b1;
  wbIdx <= idx;
  vecWbData <= d;
  @(posedge I_CLOCK);
  vecWbEn <= 1'b0;
endtask

task automatic vecCompWb(regIdxT idx, compIdxT c, logic [15:0] d);
  @(posedge I_CLOCK);
  vecCompWbEn <= 1'b1;
  wbIdx <= idx;
  compSel <= c;
  wbData <= d;
  @(posedge I_CLOCK);
  vecCompWbEn <= 1'b0;
endtask

// Holds the word until the stage takes it
task automatic issueInst(logic [31:0] w);
  int waitCycles;
  waitCycles = 0;
  @(posedge I_CLOCK);
  instValid <= 1'b1;
  instWord <= w;
  @(negedge I_CLOCK);
  while (depStall || fetchStall) begin
    waitCycles++;
    if (waitCycles > 50) begin
      $display("Instruction %h was never issued, the stage stayed stalled", w);
      failCount++;
      break;
    end
    @(negedge I_CLOCK);
  end
  @(posedge I_CLOCK);                   // Issue edge
  instValid <= 1'b0;
endtask

// File: tests/decodeTb.sv
`timescale 1ns/1ps

module decodeTb import isaPkg::*; import decodePkg::*; ();

  localparam int TEST_CYCLES = 200; // Approximate length of all tests in clocks

  logic I_CLOCK, rst, wbEn, vecWbEn, vecCompWbEn, instValid, fetchStall;
  regIdxT wbIdx;
  logic [15:0] wbData;
  logic [63:0] vecWbData;
  compIdxT compSel;
  logic [31:0] instWord;
  logic depStall, outValid, branchTaken;
  opcodeT opcode;
  regIdxT destIdx;
  logic [15:0] src1Value, src2Value, imm;
  logic [63:0] vecSrc1Value, vecSrc2Value;
  compIdxT compIdx;

  int errCount = 0, failCount = 0, outCount = 0;
  int seed = 48916;
  string testName = "reset";

  // Reference model state
  logic [15:0] sModel [16];
  logic [63:0] vModel [16];
  logic [15:0] sPendM, vPendM;
  ccT ccModel;
  logic expValid, expTaken;
  opcodeT expOp;
  regIdxT expDest;
  logic [15:0] expS1, expS2, expImm;
  logic [63:0] expV1, expV2;
  compIdxT expComp;

  decodeStage #(.numVecRegs(16)) u_dut (.*);

  `include "tbTasks.svh"

  initial begin
    I_CLOCK = 1'b0;
    forever #4 I_CLOCK = ~I_CLOCK;     // 8 ns period
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////
  task automatic checkValue(string field, logic [63:0] expV, logic [63:0] actV);
    assert (expV === actV) else begin
      $display("ERROR %s %s: expected 0x%0h, actual 0x%0h", testName, field, expV, actV);
      errCount++;
    end
  endtask

  task automatic decodeUse(opcodeT op, output logic uS1, uS2, uV1, uV2, br, setS, setV);
    uS1 = (op == OP_ADD) || (op == OP_ADDI);
    uS2 = (op == OP_ADD) || (op == OP_MOV) || (op == OP_VCOMPMOV);
    uV1 = (op == OP_VADD) || (op == OP_VMOV);
    uV2 = (op == OP_VADD);
    br  = (op >= OP_BRN) && (op <= OP_BRNZP);
    setS = (op == OP_ADD) || (op == OP_ADDI) || (op == OP_MOV) || (op == OP_MOVI);
    setV = uV1 || (op == OP_VCOMPMOV);
  endtask

  // Register value a read sees this cycle including any writeback
  function automatic logic [15:0] scalarRead(regIdxT idx);
    return (wbEn && wbIdx == idx) ? wbData : sModel[idx];
  endfunction

  function automatic logic [63:0] vecRead(regIdxT idx);
    logic [63:0] v;
    v = vModel[idx];
    if (vecWbEn && wbIdx == idx) v = vecWbData;
    if (vecCompWbEn && wbIdx == idx) v[compSel*16 +: 16] = wbData; // Only its own lane
    return v;
  endfunction

  task automatic checkOutputs();
    checkValue("outValid", 64'(expValid), 64'(outValid));
    if (outValid) outCount++;
    if (expValid) begin
      checkValue("opcode", 64'(expOp), 64'(opcode));
      checkValue("destIdx", 64'(expDest), 64'(destIdx));
      checkValue("src1Value", 64'(expS1), 64'(src1Value));
      checkValue("src2Value", 64'(expS2), 64'(src2Value));
      checkValue("vecSrc1Value", expV1, vecSrc1Value);
      checkValue("vecSrc2Value", expV2, vecSrc2Value);
      checkValue("imm", 64'(expImm), 64'(imm));
      checkValue("compIdx", 64'(expComp), 64'(compIdx));
      checkValue("branchTaken", 64'(expTaken), 64'(branchTaken));
    end
  endtask

  // Predicts the coming edge from the inputs now held
  task automatic predictCycle();
    opcodeT op;
    regIdxT s1, s2, v1, v2;
    logic uS1, uS2, uV1, uV2, br, setS, setV, stall, issueNow, vecWb;
    op = instWord[31:24];
    s1 = instWord[19:16];
    s2 = instWord[11:8];
    v1 = instWord[11:8];
    v2 = instWord[3:0];
    vecWb = vecWbEn || vecCompWbEn;
    decodeUse(op, uS1, uS2, uV1, uV2, br, setS, setV);
    stall = instValid && ((uS1 && sPendM[s1] && !(wbEn && wbIdx == s1))
                       || (uS2 && sPendM[s2] && !(wbEn && wbIdx == s2))
                       || (uV1 && vPendM[v1] && !(vecWb && wbIdx == v1))
                       || (uV2 && vPendM[v2] && !(vecWb && wbIdx == v2))
                       || (br && sPendM != 16'h0));  // No bypass for branches
    checkValue("depStall", 64'(stall), 64'(depStall));
    issueNow = instValid && !fetchStall && !stall;
    expValid = issueNow;
    if (issueNow) begin
      expOp = op;
      expDest = setV ? instWord[19:16] : instWord[23:20];
      expS1 = scalarRead(s1);
      expS2 = scalarRead(s2);
      expV1 = vecRead(v1);
      expV2 = vecRead(v2);
      expImm = instWord[15:0];
      expComp = instWord[23:22];
      expTaken = br && ((instWord[23:21] & ccModel) != 3'b000);
    end
    if (wbEn) begin
      sModel[wbIdx] = wbData;
      ccModel = wbData[15] ? 3'b100 : (wbData == 16'h0 ? 3'b010 : 3'b001);
      sPendM[wbIdx] = 1'b0;
    end
    if (vecWb) begin
      vModel[wbIdx] = vecRead(wbIdx);
      vPendM[wbIdx] = 1'b0;
    end
    if (issueNow && setS) sPendM[expDest] = 1'b1; // Set wins over clear
    if (issueNow && setV) vPendM[expDest] = 1'b1;
  endtask

  always @(negedge I_CLOCK) begin
    if (rst) begin
      for (int i = 0; i < 16; i++) begin
        sModel[i] = 16'h0;
        vModel[i] = 64'h0;
      end
      sPendM = 16'h0;
      vPendM = 16'h0;
      ccModel = 3'b010;
      expValid = 1'b0;
    end else begin
      checkOutputs();
      predictCycle();
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  function automatic logic [15:0] rnd16();
    int r;
    r = $random(seed);
    return r[15:0];
  endfunction

  function automatic logic [63:0] rnd64();
    int a, b;
    a = $random(seed);
    b = $random(seed);
    return {a, b};
  endfunction

  initial begin
    opcodeT brOps [7];
    logic [2:0] brMasks [7];
    logic [15:0] ccVals [3];
    int outsBefore;
    brOps = '{OP_BRN, OP_BRZ, OP_BRP, OP_BRNZ, OP_BRNP, OP_BRZP, OP_BRNZP};
    brMasks = '{3'b100, 3'b010, 3'b001, 3'b110, 3'b101, 3'b011, 3'b111};
    rst = 1'b1;
    wbEn = 1'b0;
    wbIdx = '0;
    wbData = '0;
    vecWbEn = 1'b0;
    vecWbData = '0;
    vecCompWbEn = 1'b0;
    compSel = '0;
    instValid = 1'b0;
    instWord = '0;
    fetchStall = 1'b0;
    repeat (10) @(posedge I_CLOCK);
    rst <= 1'b0;

    testName = "reset";                // Operands read zero
    issueInst(encAlu(OP_ADD, 4, 2, 9));
    scalarWb(4, rnd16());

    testName = "scalar";
    for (int i = 0; i < 6; i++) begin
      scalarWb(regIdxT'(i + 1), rnd16());
      scalarWb(regIdxT'(i + 8), rnd16());
      issueInst(encAlu(OP_ADD, 14, regIdxT'(i + 1), regIdxT'(i + 8)));
      scalarWb(14, rnd16());           // Retire the destination
      issueInst(encAlu(OP_MOV, 15, 0, regIdxT'(i + 8)));
      scalarWb(15, rnd16());
    end
    fork                               // Read in the writeback cycle
      issueInst(encAlu(OP_ADD, 6, 2, 3));
      scalarWb(2, rnd16());
    join
    scalarWb(6, rnd16());

    testName = "dependency";
    issueInst(encImm(OP_ADDI, 3, 1, 16'h0042));
    fork
      issueInst(encAlu(OP_ADD, 5, 3, 1));
      begin
        repeat (4) @(posedge I_CLOCK);
        scalarWb(3, rnd16());
      end
    join
    scalarWb(5, rnd16());

    testName = "vector";
    vecFullWb(2, rnd64());
    vecFullWb(4, rnd64());
    vecCompWb(4, 2, rnd16());
    issueInst(encVec(OP_VADD, 0, 1, 2, 4));
    vecFullWb(1, rnd64());
    fork                               // Partial write forwards one lane
      issueInst(encVec(OP_VADD, 0, 1, 2, 4));
      vecCompWb(2, 1, rnd16());
    join
    vecFullWb(1, rnd64());
    issueInst(encVec(OP_VCOMPMOV, 3, 5, 6, 0));
    vecCompWb(5, 3, rnd16());

    testName = "branch";
    ccVals = '{16'h8000 | rnd16(), 16'h0000, 16'h0123};
    for (int v = 0; v < 3; v++) begin
      scalarWb(1, ccVals[v]);
      for (int b = 0; b < 7; b++) issueInst(encBr(brOps[b], brMasks[b]));
    end
    issueInst(encImm(OP_ADDI, 7, 1, 16'h0001));
    fork
      issueInst(encBr(OP_BRZP, 3'b011));
      begin
        repeat (3) @(posedge I_CLOCK);
        scalarWb(7, 16'h0000);
      end
    join

    testName = "fetchStall";
    @(posedge I_CLOCK);                // Branch output is counted by now
    outsBefore = outCount;
    fork
      begin
        @(posedge I_CLOCK);
        fetchStall <= 1'b1;
        repeat (6) @(posedge I_CLOCK);
        fetchStall <= 1'b0;
      end
      issueInst(encImm(OP_MOVI, 9, 0, 16'h1234));
    join
    repeat (4) @(posedge I_CLOCK);
    assert (outCount - outsBefore == 1) else begin
      $display("Held instruction came out %0d times instead of once", outCount - outsBefore);
      failCount++;
    end
    scalarWb(9, rnd16());

    repeat (3) @(posedge I_CLOCK);
    $display("Summary: %0d value errors, %0d other failures", errCount, failCount);
    if (errCount == 0 && failCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Watchdog at twice the expected run length
  initial begin
    #(TEST_CYCLES * 8 * 2);
    $display("Watchdog expired before the tests finished");
    $display("TB FAILED");
    $finish;
  end

endmodule

// File: verilog/decodePkg.sv
package decodePkg;

  // Datapath widths
  localparam int REG_WIDTH  = 16;               // Scalar word, also one vector lane
  localparam int LANES      = 4;                // Components per vector
  localparam int VREG_WIDTH = LANES * REG_WIDTH;

  // Scalar register count, vector count is a module parameter
  localparam int NUM_SREGS = 16;

  typedef logic [3:0] regIdxT;
  typedef logic [1:0] compIdxT;

  //////////////////////////////
  // Condition code
  //////////////////////////////
  // One-hot n/z/p, same bit order as the branch mask
  typedef logic [2:0] ccT;

  localparam ccT CC_N = 3'b100;
  localparam ccT CC_Z = 3'b010;
  localparam ccT CC_P = 3'b001;

endpackage

// File: verilog/decodeStage.sv
`timescale 1ns/1ps

module decodeStage import decodePkg::*; import isaPkg::*; #(
  parameter int numVecRegs = 16
) (
  input  logic                  I_CLOCK,
  input  logic                  rst,
  input  logic                  wbEn,
  input  regIdxT                wbIdx,
  input  logic [REG_WIDTH-1:0]  wbData,
  input  logic                  vecWbEn,
  input  logic [VREG_WIDTH-1:0] vecWbData,
  input  logic                  vecCompWbEn,
  input  compIdxT               compSel,
  input  logic                  instValid,
  input  logic [INST_WIDTH-1:0] instWord,
  input  logic                  fetchStall,
  output logic                  depStall,
  output logic                  outValid,
  output opcodeT                opcode,
  output regIdxT                destIdx,
  output logic [REG_WIDTH-1:0]  src1Value,
  output logic [REG_WIDTH-1:0]  src2Value,
  output logic [VREG_WIDTH-1:0] vecSrc1Value,
  output logic [VREG_WIDTH-1:0] vecSrc2Value,
  output logic [REG_WIDTH-1:0]  imm,
  output compIdxT               compIdx,
  output logic                  branchTaken
);

  logic issue;
  regIdxT s1Idx, s2Idx, v1Idx, v2Idx, decDest;
  logic useS1, useS2, useV1, useV2, isBranch, setScalar, setVector;
  logic [REG_WIDTH-1:0] scalarRd1, scalarRd2;
  logic [VREG_WIDTH-1:0] vecRd1, vecRd2;
  ccT condCode;
  logic [LANES-1:0] laneWrEn;
  regIdxT [LANES-1:0] laneWrIdx;
  logic [LANES-1:0][REG_WIDTH-1:0] laneWrData, laneRd1, laneRd2;

  assign issue = instValid && !fetchStall && !depStall; // The one issue condition

  scalarRegFile uScalar (
    .I_CLOCK(I_CLOCK), .rst(rst), .wbEn(wbEn), .wbIdx(wbIdx), .wbData(wbData),
    .rdIdx1(s1Idx), .rdIdx2(s2Idx),
    .rdData1(scalarRd1), .rdData2(scalarRd2), .condCode(condCode)
  );

  //////////////////////////////
  // Vector register file
  //////////////////////////////
  vecWriteRouter #(.numVecRegs(numVecRegs)) uRouter (
    .vecWbEn(vecWbEn), .vecCompWbEn(vecCompWbEn), .compSel(compSel), .wbIdx(wbIdx),
    .wbData(wbData), .vecWbData(vecWbData),
    .laneWrEn(laneWrEn), .laneWrIdx(laneWrIdx), .laneWrData(laneWrData)
  );

  for (genvar l = 0; l < LANES; l++) begin : gLane
    vectorLane #(.numVecRegs(numVecRegs)) uLane (
      .I_CLOCK(I_CLOCK), .rst(rst),
      .wrEn(laneWrEn[l]), .wrIdx(laneWrIdx[l]), .wrData(laneWrData[l]),
      .rdIdx1(v1Idx), .rdIdx2(v2Idx),
      .rdData1(laneRd1[l]), .rdData2(laneRd2[l])
    );
  end

  vecOperandGather #(.numVecRegs(numVecRegs)) uGather (
    .laneRd1(laneRd1), .laneRd2(laneRd2),
    .laneWrEn(laneWrEn), .laneWrIdx(laneWrIdx), .laneWrData(laneWrData),
    .rdIdx1(v1Idx), .rdIdx2(v2Idx), .vecSrc1(vecRd1), .vecSrc2(vecRd2)
  );

  //////////////////////////////
  // Hazards and decode
  //////////////////////////////
  scoreboard #(.numVecRegs(numVecRegs)) uScoreboard (
    .I_CLOCK(I_CLOCK), .rst(rst), .instValid(instValid), .issue(issue),
    .isBranch(isBranch), .useS1(useS1), .useS2(useS2), .useV1(useV1), .useV2(useV2),
    .s1Idx(s1Idx), .s2Idx(s2Idx), .v1Idx(v1Idx), .v2Idx(v2Idx),
    .setScalar(setScalar), .setVector(setVector), .destIdx(decDest),
    .wbEn(wbEn), .vecWbEn(vecWbEn), .vecCompWbEn(vecCompWbEn), .wbIdx(wbIdx),
    .depStall(depStall)
  );

  instDecoder uDecoder (
    .I_CLOCK(I_CLOCK), .rst(rst), .instWord(instWord), .issue(issue),
    .scalarRd1(scalarRd1), .scalarRd2(scalarRd2), .vecRd1(vecRd1), .vecRd2(vecRd2),
    .condCode(condCode),
    .s1Idx(s1Idx), .s2Idx(s2Idx), .v1Idx(v1Idx), .v2Idx(v2Idx),
    .useS1(useS1), .useS2(useS2), .useV1(useV1), .useV2(useV2), .isBranch(isBranch),
    .setScalar(setScalar), .setVector(setVector), .nextDestIdx(decDest),
    .outValid(outValid), .opcode(opcode), .destIdx(destIdx),
    .src1Value(src1Value), .src2Value(src2Value),
    .vecSrc1Value(vecSrc1Value), .vecSrc2Value(vecSrc2Value),
    .imm(imm), .compIdx(compIdx), .branchTaken(branchTaken)
  );

endmodule

// File: verilog/instDecoder.sv
`timescale 1ns/1ps

module instDecoder import decodePkg::*; import isaPkg::*; (
  input  logic                  I_CLOCK,
  input  logic                  rst,
  input  logic [INST_WIDTH-1:0] instWord,
  input  logic                  issue,
  input  logic [REG_WIDTH-1:0]  scalarRd1,
  input  logic [REG_WIDTH-1:0]  scalarRd2,
  input  logic [VREG_WIDTH-1:0] vecRd1,
  input  logic [VREG_WIDTH-1:0] vecRd2,
  input  ccT                    condCode,
  output regIdxT                s1Idx,
  output regIdxT                s2Idx,
  output regIdxT                v1Idx,
  output regIdxT                v2Idx,
  output logic                  useS1,
  output logic                  useS2,
  output logic                  useV1,
  output logic                  useV2,
  output logic                  isBranch,
  output logic                  setScalar,
  output logic                  setVector,
  output regIdxT                nextDestIdx,   // Destination of the word at the input
  output logic                  outValid,
  output opcodeT                opcode,
  output regIdxT                destIdx,
  output logic [REG_WIDTH-1:0]  src1Value,
  output logic [REG_WIDTH-1:0]  src2Value,
  output logic [VREG_WIDTH-1:0] vecSrc1Value,
  output logic [VREG_WIDTH-1:0] vecSrc2Value,
  output logic [REG_WIDTH-1:0]  imm,
  output compIdxT               compIdx,
  output logic                  branchTaken
);

  opcodeT op;
  regIdxT sDest, vDest;
  ccT     brMask;
  logic   takenNow;

  //////////////////////////////
  // Field extraction
  //////////////////////////////
  assign op     = opcodeT'(instWord[OPCODE_HI:OPCODE_LO]);
  assign s1Idx  = instWord[SRC1_HI:SRC1_LO];
  assign s2Idx  = instWord[SRC2_HI:SRC2_LO];
  assign v1Idx  = instWord[VSRC1_HI:VSRC1_LO];
  assign v2Idx  = instWord[VSRC2_HI:VSRC2_LO];
  assign sDest  = instWord[DEST_HI:DEST_LO];
  assign vDest  = instWord[VDEST_HI:VDEST_LO];
  assign brMask = {instWord[BR_N_BIT], instWord[BR_Z_BIT], instWord[BR_P_BIT]};

  // Source use and destination kind per opcode
  always_comb begin
    useS1     = 1'b0;
    useS2     = 1'b0;
    useV1     = 1'b0;
    useV2     = 1'b0;
    isBranch  = 1'b0;
    setScalar = 1'b0;
    setVector = 1'b0;
    case (op)
      OP_ADD:  begin useS1 = 1'b1; useS2 = 1'b1; setScalar = 1'b1; end
      OP_ADDI: begin useS1 = 1'b1; setScalar = 1'b1; end
      OP_MOV:  begin useS2 = 1'b1; setScalar = 1'b1; end
      OP_MOVI: setScalar = 1'b1;           // Immediate only
      OP_BRN, OP_BRZ, OP_BRP, OP_BRNZ, OP_BRNP, OP_BRZP, OP_BRNZP:
        isBranch = 1'b1;
      OP_VADD: begin useV1 = 1'b1; useV2 = 1'b1; setVector = 1'b1; end
      OP_VMOV: begin useV1 = 1'b1; setVector = 1'b1; end
      OP_VCOMPMOV: begin useS2 = 1'b1; setVector = 1'b1; end // Scalar in, one lane out
      default: ;                           // Unknown opcode passes as a no-op
    endcase
  end

  assign nextDestIdx = setVector ? vDest : sDest;
  assign takenNow    = isBranch && (|(brMask & condCode));

  //////////////////////////////
  // Decode output register
  //////////////////////////////
  always_ff @(posedge I_CLOCK) begin
    if (rst) outValid <= 1'b0;
    else     outValid <= issue; // One cycle per issued instruction
  end

  always_ff @(posedge I_CLOCK) begin
    if (issue) begin
      opcode       <= op;
      destIdx      <= nextDestIdx;
      src1Value    <= scalarRd1;
      src2Value    <= scalarRd2;
      vecSrc1Value <= vecRd1;
      vecSrc2Value <= vecRd2;
      imm          <= instWord[IMM_HI:IMM_LO];
      compIdx      <= instWord[COMP_HI:COMP_LO];
      branchTaken  <= takenNow;
    end
  end

endmodule

// File: verilog/isaPkg.sv
package isaPkg;

  typedef logic [7:0] opcodeT;

  localparam int INST_WIDTH = 32;

  //////////////////////////////
  // Opcodes
  //////////////////////////////
  localparam opcodeT OP_ADD      = 8'h00; // Rd = Rs1 + Rs2
  localparam opcodeT OP_ADDI     = 8'h01; // Rd = Rs1 + imm
  localparam opcodeT OP_MOV      = 8'h09; // Rd = Rs2
  localparam opcodeT OP_MOVI     = 8'h0A; // Rd = imm
  // Conditional branches, taken on mask & cc
  localparam opcodeT OP_BRN      = 8'h20;
  localparam opcodeT OP_BRZ      = 8'h21;
  localparam opcodeT OP_BRP      = 8'h22;
  localparam opcodeT OP_BRNZ     = 8'h23;
  localparam opcodeT OP_BRNP     = 8'h24;
  localparam opcodeT OP_BRZP     = 8'h25;
  localparam opcodeT OP_BRNZP    = 8'h26;
  localparam opcodeT OP_VADD     = 8'h30; // Lane-wise add
  localparam opcodeT OP_VMOV     = 8'h31;
  localparam opcodeT OP_VCOMPMOV = 8'h33; // Scalar into one component

  //////////////////////////////
  // Field positions
  //////////////////////////////
  localparam int OPCODE_HI = 31;
  localparam int OPCODE_LO = 24;
  localparam int DEST_HI   = 23; // Scalar destination
  localparam int DEST_LO   = 20;
  localparam int SRC1_HI   = 19;
  localparam int SRC1_LO   = 16;
  localparam int SRC2_HI   = 11; // Also the VCOMPMOV scalar source
  localparam int SRC2_LO   = 8;
  localparam int IMM_HI    = 15;
  localparam int IMM_LO    = 0;
  localparam int VDEST_HI  = 19;
  localparam int VDEST_LO  = 16;
  localparam int VSRC1_HI  = 11;
  localparam int VSRC1_LO  = 8;
  localparam int VSRC2_HI  = 3;
  localparam int VSRC2_LO  = 0;
  localparam int COMP_HI   = 23; // Component select for VCOMPMOV
  localparam int COMP_LO   = 22;
  localparam int BR_N_BIT  = 23; // Branch mask n/z/p
  localparam int BR_Z_BIT  = 22;
  localparam int BR_P_BIT  = 21;

endpackage

// File: verilog/scalarRegFile.sv
`timescale 1ns/1ps

module scalarRegFile import decodePkg::*; (
  input  logic                 I_CLOCK,
  input  logic                 rst,
  input  logic                 wbEn,
  input  regIdxT               wbIdx,
  input  logic [REG_WIDTH-1:0] wbData,
  input  regIdxT               rdIdx1,
  input  regIdxT               rdIdx2,
  output logic [REG_WIDTH-1:0] rdData1,
  output logic [REG_WIDTH-1:0] rdData2,
  output ccT                   condCode
);

  logic [REG_WIDTH-1:0] regs [NUM_SREGS];
  ccT nextCc; // Code for the word now being written

  // Sign bit first, then zero test
  always_comb begin
    if (wbData[REG_WIDTH-1]) begin
      nextCc = CC_N;
    end else if (wbData == '0) begin
      nextCc = CC_Z;
    end else begin
      nextCc = CC_P;
    end
  end

  always_ff @(posedge I_CLOCK) begin
    if (rst) begin
      for (int i = 0; i < NUM_SREGS; i++) begin
        regs[i] <= '0;               // Registers read zero after reset
      end
      condCode <= CC_Z;              // Matches the all-zero file
    end else if (wbEn) begin
      regs[wbIdx] <= wbData;
      condCode    <= nextCc;         // CC follows scalar writebacks only
    end
  end

  // Same-cycle writeback bypass
  assign rdData1 = (wbEn && (wbIdx == rdIdx1)) ? wbData : regs[rdIdx1];
  assign rdData2 = (wbEn && (wbIdx == rdIdx2)) ? wbData : regs[rdIdx2];

endmodule

// File: verilog/scoreboard.sv
`timescale 1ns/1ps

module scoreboard import decodePkg::*; #(
  parameter int numVecRegs = 16
) (
  input  logic   I_CLOCK,
  input  logic   rst,
  input  logic   instValid,
  input  logic   issue,
  input  logic   isBranch,
  input  logic   useS1,
  input  logic   useS2,
  input  logic   useV1,
  input  logic   useV2,
  input  regIdxT s1Idx,
  input  regIdxT s2Idx,
  input  regIdxT v1Idx,
  input  regIdxT v2Idx,
  input  logic   setScalar,
  input  logic   setVector,
  input  regIdxT destIdx,
  input  logic   wbEn,
  input  logic   vecWbEn,
  input  logic   vecCompWbEn,
  input  regIdxT wbIdx,
  output logic   depStall
);

  localparam int vIdxW = $clog2(numVecRegs);

  logic [NUM_SREGS-1:0]  sPend, sSet, sClr; // Scalar pending bits
  logic [numVecRegs-1:0] vPend, vSet, vClr; // Vector pending bits
  logic vecWb;                              // Either kind of vector writeback
  logic s1Wait, s2Wait, v1Wait, v2Wait, brWait;

  assign vecWb = vecWbEn || vecCompWbEn;

  //////////////////////////////
  // Pending bit update
  //////////////////////////////
  always_comb begin
    sSet = '0;
    sClr = '0;
    vSet = '0;
    vClr = '0;
    if (issue && setScalar) sSet[destIdx] = 1'b1;
    if (issue && setVector) vSet[destIdx[vIdxW-1:0]] = 1'b1;
    if (wbEn) sClr[wbIdx] = 1'b1;
    if (vecWb) vClr[wbIdx[vIdxW-1:0]] = 1'b1;
  end

  always_ff @(posedge I_CLOCK) begin
    if (rst) begin
      sPend <= '0;
      vPend <= '0;
    end else begin
      sPend <= (sPend & ~sClr) | sSet; // Set wins over a clear at the same edge
      vPend <= (vPend & ~vClr) | vSet;
    end
  end

  //////////////////////////////
  // Stall decision
  //////////////////////////////
  // A pending source is fine if its writeback arrives now
  assign s1Wait = useS1 && sPend[s1Idx] && !(wbEn && (wbIdx == s1Idx));
  assign s2Wait = useS2 && sPend[s2Idx] && !(wbEn && (wbIdx == s2Idx));
  assign v1Wait = useV1 && vPend[v1Idx[vIdxW-1:0]]
                  && !(vecWb && (wbIdx[vIdxW-1:0] == v1Idx[vIdxW-1:0]));
  assign v2Wait = useV2 && vPend[v2Idx[vIdxW-1:0]]
                  && !(vecWb && (wbIdx[vIdxW-1:0] == v2Idx[vIdxW-1:0]));
  assign brWait = isBranch && (|sPend); // CC not final yet, no bypass

  assign depStall = instValid && (s1Wait || s2Wait || v1Wait || v2Wait || brWait);

endmodule

// File: verilog/vecOperandGather.sv
`timescale 1ns/1ps

module vecOperandGather import decodePkg::*; #(
  parameter int numVecRegs = 16
) (
  input  logic [LANES-1:0][REG_WIDTH-1:0] laneRd1,
  input  logic [LANES-1:0][REG_WIDTH-1:0] laneRd2,
  input  logic [LANES-1:0]                laneWrEn,
  input  regIdxT [LANES-1:0]              laneWrIdx,
  input  logic [LANES-1:0][REG_WIDTH-1:0] laneWrData,
  input  regIdxT                          rdIdx1,
  input  regIdxT                          rdIdx2,
  output logic [VREG_WIDTH-1:0]           vecSrc1,
  output logic [VREG_WIDTH-1:0]           vecSrc2
);

  localparam int vIdxW = $clog2(numVecRegs);

  logic [LANES-1:0] hit1; // Lane written at the operand's index this cycle
  logic [LANES-1:0] hit2;

  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      // Compare in the folded range the lanes use
      hit1[l] = laneWrEn[l] && (laneWrIdx[l][vIdxW-1:0] == rdIdx1[vIdxW-1:0]);
      hit2[l] = laneWrEn[l] && (laneWrIdx[l][vIdxW-1:0] == rdIdx2[vIdxW-1:0]);
      // Per lane, so a component write only replaces its own slice
      vecSrc1[l*REG_WIDTH +: REG_WIDTH] = hit1[l] ? laneWrData[l] : laneRd1[l];
      vecSrc2[l*REG_WIDTH +: REG_WIDTH] = hit2[l] ? laneWrData[l] : laneRd2[l];
    end
  end

endmodule

// File: verilog/vecWriteRouter.sv
`timescale 1ns/1ps

module vecWriteRouter import decodePkg::*; #(
  parameter int numVecRegs = 16
) (
  input  logic                            vecWbEn,
  input  logic                            vecCompWbEn,
  input  compIdxT                         compSel,
  input  regIdxT                          wbIdx,
  input  logic [REG_WIDTH-1:0]            wbData,
  input  logic [VREG_WIDTH-1:0]           vecWbData,
  output logic [LANES-1:0]                laneWrEn,
  output regIdxT [LANES-1:0]              laneWrIdx,
  output logic [LANES-1:0][REG_WIDTH-1:0] laneWrData
);

  localparam int vIdxW = $clog2(numVecRegs);

  regIdxT foldIdx; // Index folded into the implemented register range

  assign foldIdx = regIdxT'(wbIdx[vIdxW-1:0]);

  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      // Full write hits every lane, component write only the selected one
      laneWrEn[l]   = vecWbEn || (vecCompWbEn && (compSel == compIdxT'(l)));
      laneWrIdx[l]  = foldIdx;
      // Scalar word replaces the slice on a component write
      laneWrData[l] = vecCompWbEn ? wbData : vecWbData[l*REG_WIDTH +: REG_WIDTH];
    end
  end

endmodule

// File: verilog/vectorLane.sv
`timescale 1ns/1ps

module vectorLane import decodePkg::*; #(
  parameter int numVecRegs = 16
) (
  input  logic                 I_CLOCK,
  input  logic                 rst,
  input  logic                 wrEn,
  input  regIdxT               wrIdx,
  input  logic [REG_WIDTH-1:0] wrData,
  input  regIdxT               rdIdx1,
  input  regIdxT               rdIdx2,
  output logic [REG_WIDTH-1:0] rdData1,
  output logic [REG_WIDTH-1:0] rdData2
);

  localparam int vIdxW = $clog2(numVecRegs);

  // One component of every vector register
  logic [REG_WIDTH-1:0] comp [numVecRegs];

  always_ff @(posedge I_CLOCK) begin
    if (rst) begin
      for (int i = 0; i < numVecRegs; i++) begin
        comp[i] <= '0;
      end
    end else if (wrEn) begin
      comp[wrIdx[vIdxW-1:0]] <= wrData;
    end
  end

  // Plain reads, bypass lives in the gatherer
  assign rdData1 = comp[rdIdx1[vIdxW-1:0]];
  assign rdData2 = comp[rdIdx2[vIdxW-1:0]];

endmodule
